// File: Bender.yml
package:
  name: spuTransfer

sources:
  - src/spuPkg.sv
  - src/spuRegs.sv
  - src/spuTransferFifo.sv
  - src/spuTransferEngine.sv
  - src/spuTransferTop.sv
  - target: test
    files:
      - tests/tbClockGen.sv
      - tests/spuTransferTb.sv

// File: spuTransferTop.f
src/spuPkg.sv
src/spuRegs.sv
src/spuTransferFifo.sv
src/spuTransferEngine.sv
src/spuTransferTop.sv
tests/tbClockGen.sv
tests/spuTransferTb.sv

// File: src/spuPkg.sv
`default_nettype none

package spuPkg;

	// ------------------------------
	// Widths with a meaning
	// ------------------------------

	// One RAM or register data word
	typedef logic [15:0] word_t;
	// Sound RAM halfword address
	typedef logic [17:0] ramAddr_t;
	// CPU byte address inside the sound block
	typedef logic [9:0]  regAddr_t;

	// Transfer mode as held in control bits 5:4
	typedef enum logic [1:0] {
		ModeStop     = 2'd0,
		ModeManual   = 2'd1,
		ModeDmaWrite = 2'd2,
		ModeDmaRead  = 2'd3
	} xferMode_e;

	// Transfer engine FSM
	typedef enum logic [1:0] {
		StSlotWait   = 2'd0,
		StFifoWrite  = 2'd1,
		StDmaPresent = 2'd2
	} engineState_e;

	// ------------------------------
	// Register map
	// ------------------------------
	localparam regAddr_t RegIrqAddr  = 10'h1A4;
	localparam regAddr_t RegXferAddr = 10'h1A6;
	localparam regAddr_t RegXferFifo = 10'h1A8;
	localparam regAddr_t RegCtrl     = 10'h1AA;
	localparam regAddr_t RegStat     = 10'h1AE;

	// Bit positions in control and status
	localparam int CtrlIrqEnableBit = 6;
	localparam int StatBusyBit      = 10;
	localparam int StatIrqBit       = 6;
	// Mode field, same place in both registers
	localparam int ModeMsb          = 5;
	localparam int ModeLsb          = 4;

	// ------------------------------
	// Bundles
	// ------------------------------

	// CPU side strobes, no handshake
	typedef struct packed {
		logic     cs;
		logic     rd;
		logic     wr;
		regAddr_t addr;
		word_t    wdata;
	} cpuBus_t;

	// One sound RAM access
	typedef struct packed {
		ramAddr_t addr;
		logic     read;
		logic     write;
		word_t    wdata;
	} ramReq_t;

	// Register block to transfer engine
	typedef struct packed {
		xferMode_e mode;
		logic      loadAddr;
		word_t     startAddr;
	} xferCtrl_t;

endpackage

`default_nettype wire

// File: src/spuRegs.sv
`timescale 1ns/1ps
`default_nettype none

module spuRegs import spuPkg::*; (
	input  wire logic      i_clk,
	input  wire logic      i_rstN,

	// CPU register port
	input  wire cpuBus_t   i_cpu,

	// RAM access seen by the engine, watched for the IRQ address
	input  wire ramReq_t   i_ram,
	// Transfer busy level from the engine
	input  wire logic      i_busy,

	output xferCtrl_t      o_ctrl,
	output logic           o_cpuPush,
	output word_t          o_dataOut,
	output logic           o_dataOutValid,
	output logic           o_irq
);

	// Qualified strobes
	logic  cpuWr;
	logic  cpuRd;

	// Register contents
	word_t irqAddr;
	word_t startAddr;
	word_t ctrlReg;
	logic  loadAddr;

	// Interrupt
	logic  irqFlag;
	logic  irqEnable;
	logic  irqHit;

	// Read path
	word_t statWord;
	word_t readMux;

	assign cpuWr = i_cpu.cs & i_cpu.wr;
	assign cpuRd = i_cpu.cs & i_cpu.rd;

	// FIFO push straight from the decode, one per write strobe
	assign o_cpuPush = cpuWr && (i_cpu.addr == RegXferFifo);

	// ------------------------------
	// Register writes
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			irqAddr  <= '0;
			ctrlReg  <= '0;
			loadAddr <= 1'b0;
		end else begin
			// Load strobe lasts one cycle
			loadAddr <= 1'b0;
			if (cpuWr) begin
				case (i_cpu.addr)
					RegIrqAddr:  irqAddr  <= i_cpu.wdata;
					RegCtrl:     ctrlReg  <= i_cpu.wdata;
					RegXferAddr: loadAddr <= 1'b1;
					default:     ;
				endcase
			end
		end
	end

	// Start address, consumed by the engine on the cycle after the write
	always_ff @(posedge i_clk) begin
		if (cpuWr && (i_cpu.addr == RegXferAddr)) begin
			startAddr <= i_cpu.wdata;
		end
	end

	// Control bundle to the engine
	always_comb begin
		o_ctrl.mode      = xferMode_e'(ctrlReg[ModeMsb:ModeLsb]);
		o_ctrl.loadAddr  = loadAddr;
		o_ctrl.startAddr = startAddr;
	end

	// ------------------------------
	// Register reads
	// ------------------------------

	// Status is built live
	always_comb begin
		statWord                  = '0;
		statWord[StatBusyBit]     = i_busy;
		statWord[StatIrqBit]      = irqFlag;
		statWord[ModeMsb:ModeLsb] = ctrlReg[ModeMsb:ModeLsb];
	end

	always_comb begin
		case (i_cpu.addr)
			RegIrqAddr:  readMux = irqAddr;
			RegXferAddr: readMux = startAddr;
			RegCtrl:     readMux = ctrlReg;
			RegStat:     readMux = statWord;
			// FIFO port and unmapped offsets read as zero
			default:     readMux = '0;
		endcase
	end

	// Data lands one cycle after the strobe
	always_ff @(posedge i_clk) begin
		if (cpuRd) begin
			o_dataOut <= readMux;
		end
	end

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_dataOutValid <= 1'b0;
		end else begin
			o_dataOutValid <= cpuRd;
		end
	end

	// ------------------------------
	// RAM address interrupt
	// ------------------------------
	assign irqEnable = ctrlReg[CtrlIrqEnableBit];

	// Compare on word granularity, low 2 bits dropped
	assign irqHit = irqEnable && (i_ram.read || i_ram.write)
		&& (i_ram.addr[17:2] == irqAddr);

	// Sticky until enable goes low
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			irqFlag <= 1'b0;
		end else if (!irqEnable) begin
			irqFlag <= 1'b0;
		end else if (irqHit) begin
			irqFlag <= 1'b1;
		end
	end

	assign o_irq = irqFlag;

endmodule

`default_nettype wire

// File: src/spuTransferEngine.sv
`timescale 1ns/1ps
`default_nettype none

module spuTransferEngine import spuPkg::*; #(
	parameter int SlotPeriod = 8
) (
	input  wire logic      i_clk,
	input  wire logic      i_rstN,
	input  wire xferCtrl_t i_ctrl,

	// FIFO side
	input  wire logic      i_fifoEmpty,
	input  wire logic      i_fifoFull,
	input  wire word_t     i_fifoData,

	// RAM read data, one cycle after o_ram.read
	input  wire word_t     i_ramData,
	input  wire logic      i_dmaAck,

	output logic           o_fifoPop,
	output logic           o_dmaPush,
	output ramReq_t        o_ram,
	output logic           o_dmaReq,
	output word_t          o_dmaData,
	output logic           o_busy
);

	localparam int CntWidth = $clog2(SlotPeriod + 1);
	localparam logic [CntWidth-1:0] CntReload = CntWidth'(SlotPeriod - 1);

	logic [CntWidth-1:0] slotCnt;
	logic                slot;

	engineState_e        state;
	engineState_e        stateNext;

	// Current transfer address and the word in flight to RAM
	ramAddr_t            curAddr;
	word_t               wrWord;

	logic                isFifoMode;
	logic                isDmaWrite;
	logic                isDmaRead;
	logic                incAddr;
	logic                dmaPulse;

	// Mode decode
	assign isDmaWrite = (i_ctrl.mode == ModeDmaWrite);
	assign isDmaRead  = (i_ctrl.mode == ModeDmaRead);
	// FIFO drains in manual and DMA write
	assign isFifoMode = (i_ctrl.mode == ModeManual) || isDmaWrite;

	// ------------------------------
	// Slot timing
	// ------------------------------

	// Stand-in for the free RAM cycles, one every SlotPeriod clocks
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			slotCnt <= CntReload;
		end else if (slotCnt == '0) begin
			slotCnt <= CntReload;
		end else begin
			slotCnt <= slotCnt - 1'b1;
		end
	end

	assign slot = (slotCnt == '0);

	// ------------------------------
	// FSM
	// ------------------------------
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			state <= StSlotWait;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext     = state;
		o_fifoPop     = 1'b0;
		incAddr       = 1'b0;
		dmaPulse      = 1'b0;
		o_ram.addr    = curAddr;
		o_ram.read    = 1'b0;
		o_ram.write   = 1'b0;
		o_ram.wdata   = wrWord;
		case (state)
			StSlotWait: begin
				// Drain in the FIFO modes and read in DMA read
				if (slot && isFifoMode && !i_fifoEmpty) begin
					o_fifoPop = 1'b1;
					stateNext = StFifoWrite;
				end else if (slot && isDmaRead) begin
					o_ram.read = 1'b1;
					stateNext  = StDmaPresent;
				end
			end
			StFifoWrite: begin
				// Popped word goes out, then step the address
				o_ram.write = 1'b1;
				incAddr     = 1'b1;
				stateNext   = StSlotWait;
			end
			StDmaPresent: begin
				// RAM word valid now
				dmaPulse  = isDmaRead;
				// No ack means same address again next slot
				incAddr   = isDmaRead && i_dmaAck;
				stateNext = StSlotWait;
			end
			default: stateNext = StSlotWait;
		endcase
	end

	// Hold the popped word for the write cycle
	always_ff @(posedge i_clk) begin
		if (o_fifoPop) begin
			wrWord <= i_fifoData;
		end
	end

	// Address load wins over increment
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			curAddr <= '0;
		end else if (i_ctrl.loadAddr) begin
			curAddr <= {i_ctrl.startAddr, 2'b00};
		end else if (incAddr) begin
			curAddr <= curAddr + 1'b1;
		end
	end

	// ------------------------------
	// DMA side
	// ------------------------------

	// Level while room in DMA write, single pulse in DMA read
	assign o_dmaReq  = dmaPulse || (isDmaWrite && !i_fifoFull);
	// FIFO drops it when full
	assign o_dmaPush = isDmaWrite && i_dmaAck;
	assign o_dmaData = i_ramData;

	assign o_busy    = !i_fifoEmpty || isDmaRead;

endmodule

`default_nettype wire

// File: src/spuTransferFifo.sv
`timescale 1ns/1ps
`default_nettype none

module spuTransferFifo import spuPkg::*; #(
	parameter int FifoDepthLog2 = 5
) (
	input  wire logic   i_clk,
	input  wire logic   i_rstN,
	input  wire logic   i_push,
	input  wire logic   i_pop,
	input  wire word_t  i_data,
	output word_t       o_data,
	output logic        o_full,
	output logic        o_empty
);

	localparam int Depth = 1 << FifoDepthLog2;

	// Storage
	word_t mem [Depth];

	// Extra MSB on each pointer tells full from empty
	logic [FifoDepthLog2:0] wrPtr;
	logic [FifoDepthLog2:0] rdPtr;

	logic doPush;
	logic doPop;

	// Push on full and pop on empty are dropped
	assign doPush = i_push && !o_full;
	assign doPop  = i_pop && !o_empty;

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (doPush) begin
			mem[wrPtr[FifoDepthLog2-1:0]] <= i_data;
		end
	end

	// Head word always visible
	assign o_data  = mem[rdPtr[FifoDepthLog2-1:0]];

	assign o_empty = (wrPtr == rdPtr);
	// Same slot, wrapped once
	assign o_full  = (wrPtr[FifoDepthLog2] != rdPtr[FifoDepthLog2])
		&& (wrPtr[FifoDepthLog2-1:0] == rdPtr[FifoDepthLog2-1:0]);

endmodule

`default_nettype wire

// File: src/spuTransferTop.sv
`timescale 1ns/1ps
`default_nettype none

module spuTransferTop import spuPkg::*; #(
	parameter int FifoDepthLog2 = 5,
	parameter int SlotPeriod    = 8
) (
	input  wire logic    i_clk,
	input  wire logic    i_rstN,

	// CPU port
	input  wire cpuBus_t i_cpu,
	output word_t        o_dataOut,
	output logic         o_dataOutValid,
	output logic         o_irq,

	// DMA pair
	output logic         o_dmaReq,
	input  wire logic    i_dmaAck,

	// Sound RAM
	output ramReq_t      o_ram,
	input  wire word_t   i_ramData
);

	xferCtrl_t xferCtrl;

	logic      cpuPush;
	logic      dmaPush;
	logic      fifoPush;
	logic      fifoPop;
	logic      fifoFull;
	logic      fifoEmpty;
	logic      busy;

	word_t     fifoData;
	word_t     regData;
	word_t     dmaData;

	// ------------------------------
	// Register block
	// ------------------------------
	spuRegs regsInst (
		.i_clk          (i_clk),
		.i_rstN         (i_rstN),
		.i_cpu          (i_cpu),
		.i_ram          (o_ram),
		.i_busy         (busy),
		.o_ctrl         (xferCtrl),
		.o_cpuPush      (cpuPush),
		.o_dataOut      (regData),
		.o_dataOutValid (o_dataOutValid),
		.o_irq          (o_irq)
	);

	// CPU and DMA share the write data bus, never both at once
	assign fifoPush = cpuPush | dmaPush;

	spuTransferFifo #(
		.FifoDepthLog2 (FifoDepthLog2)
	) fifoInst (
		.i_clk   (i_clk),
		.i_rstN  (i_rstN),
		.i_push  (fifoPush),
		.i_pop   (fifoPop),
		.i_data  (i_cpu.wdata),
		.o_data  (fifoData),
		.o_full  (fifoFull),
		.o_empty (fifoEmpty)
	);

	spuTransferEngine #(
		.SlotPeriod (SlotPeriod)
	) engineInst (
		.i_clk       (i_clk),
		.i_rstN      (i_rstN),
		.i_ctrl      (xferCtrl),
		.i_fifoEmpty (fifoEmpty),
		.i_fifoFull  (fifoFull),
		.i_fifoData  (fifoData),
		.i_ramData   (i_ramData),
		.i_dmaAck    (i_dmaAck),
		.o_fifoPop   (fifoPop),
		.o_dmaPush   (dmaPush),
		.o_ram       (o_ram),
		.o_dmaReq    (o_dmaReq),
		.o_dmaData   (dmaData),
		.o_busy      (busy)
	);

	// RAM word on the bus during the DMA read pulse
	assign o_dataOut = (o_dmaReq && (xferCtrl.mode == ModeDmaRead)) ? dmaData : regData;

endmodule

`default_nettype wire

// File: tests/spuTransferTb.sv
`timescale 1ns/1ps
`default_nettype none

module spuTransferTb import spuPkg::*; ();

	localparam int FifoDepthLog2 = 5;
	localparam int SlotPeriod    = 8;
	localparam int Timeout       = 1000;
	// DMA read pulse that gets no acknowledge
	localparam int SkipPulse     = 2;

	logic     clk;
	logic     rstN;
	cpuBus_t  cpuBus;
	logic     dmaAck;
	word_t    ramData;
	word_t    dataOut;
	logic     dataOutValid;
	logic     irq;
	logic     dmaReq;
	ramReq_t  ram;

	// Sound RAM model with a log of every write
	word_t    ramMem [0:(1<<18)-1];
	ramAddr_t wrAddrQ[$];
	word_t    wrDataQ[$];
	word_t    expQ[$];

	logic [15:0] lfsrState;
	int          errCount;
	int          errAtStart;
	int          testCount;
	int          failedTests;

	tbClockGen clkGen (
		.o_clk  (clk),
		.o_rstN (rstN)
	);

	spuTransferTop #(
		.FifoDepthLog2 (FifoDepthLog2),
		.SlotPeriod    (SlotPeriod)
	) uut (
		.i_clk          (clk),
		.i_rstN         (rstN),
		.i_cpu          (cpuBus),
		.o_dataOut      (dataOut),
		.o_dataOutValid (dataOutValid),
		.o_irq          (irq),
		.o_dmaReq       (dmaReq),
		.i_dmaAck       (dmaAck),
		.o_ram          (ram),
		.i_ramData      (ramData)
	);

	// Read data one cycle after the request
	always @(posedge clk) begin
		if (ram.read) begin
			ramData <= ramMem[ram.addr];
		end
		if (ram.write) begin
			ramMem[ram.addr] <= ram.wdata;
			wrAddrQ.push_back(ram.addr);
			wrDataQ.push_back(ram.wdata);
		end
	end

	// ------------------------------
	// Protocol checks
	// ------------------------------

	// Acknowledge only against a pending request
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN) dmaAck |-> dmaReq)
		else begin
			$display("DMA acknowledge given while no request was pending");
			errCount++;
		end

	// Valid exactly one cycle after a read strobe, never otherwise
	validAfterRead: assert property (@(posedge clk) disable iff (!rstN)
		(cpuBus.cs && cpuBus.rd) |=> dataOutValid)
		else begin
			$display("Fail o_dataOutValid exp 1 got %h", $sampled(dataOutValid));
			errCount++;
		end

	validOnlyAfterRead: assert property (@(posedge clk) disable iff (!rstN)
		!(cpuBus.cs && cpuBus.rd) |=> !dataOutValid)
		else begin
			$display("Fail o_dataOutValid exp 0 got %h", $sampled(dataOutValid));
			errCount++;
		end

	// ------------------------------
	// Helpers
	// ------------------------------

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per bit taken
	task automatic nextBits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
	endtask

	function automatic word_t ctrlWord(input xferMode_e mode, input logic irqEn);
		word_t w;
		w = '0;
		w[ModeMsb:ModeLsb] = mode;
		w[CtrlIrqEnableBit] = irqEn;
		return w;
	endfunction

	function automatic word_t expStat(input xferMode_e mode, input logic busy, input logic irqSet);
		word_t w;
		w = '0;
		w[ModeMsb:ModeLsb] = mode;
		w[StatBusyBit] = busy;
		w[StatIrqBit] = irqSet;
		return w;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
			else begin
				$display("Fail %s exp %h got %h", name, exp, got);
				errCount++;
			end
	endtask

	task automatic timeoutAbort(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test failures found");
		$finish;
	endtask

	task automatic reportTest(input string name);
		testCount++;
		if (errCount == errAtStart) begin
			$display("Test %0d %s: ok", testCount, name);
		end else begin
			failedTests++;
			$display("Test %0d %s: FAILED", testCount, name);
		end
		errAtStart = errCount;
	endtask

	// One-cycle write strobe
	task automatic cpuWrite(input regAddr_t offs, input word_t data);
		@(posedge clk);
		cpuBus <= '{cs: 1'b1, rd: 1'b0, wr: 1'b1, addr: offs, wdata: data};
		@(posedge clk);
		cpuBus <= '0;
	endtask

	task automatic cpuRead(input regAddr_t offs, output word_t data);
		int cycles;
		@(posedge clk);
		cpuBus <= '{cs: 1'b1, rd: 1'b1, wr: 1'b0, addr: offs, wdata: 16'h0};
		@(posedge clk);
		cpuBus <= '0;
		cycles = 1;
		@(negedge clk);
		while (!dataOutValid) begin
			if (cycles >= Timeout) timeoutAbort("read data valid");
			cycles++;
			@(negedge clk);
		end
		checkEq("o_dataOutValid latency", 1, cycles);
		data = dataOut;
	endtask

	// ------------------------------
	// Wait loops
	// ------------------------------
	task automatic waitDmaReq();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!dmaReq) begin
			if (cycles >= Timeout) timeoutAbort("DMA request");
			cycles++;
			@(negedge clk);
		end
	endtask

	// Returns in the middle of the read cycle
	task automatic waitRamRead();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!ram.read) begin
			if (cycles >= Timeout) timeoutAbort("RAM read");
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic waitWrites(input int n);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (wrAddrQ.size() < n) begin
			if (cycles >= Timeout) timeoutAbort("RAM writes");
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic waitIrqHigh();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!irq) begin
			if (cycles >= Timeout) timeoutAbort("interrupt");
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic checkWrites(input ramAddr_t base, input int n);
		checkEq("RAM write count", n, wrAddrQ.size());
		for (int i = 0; i < n && i < wrAddrQ.size(); i++) begin
			checkEq("o_ram.addr", ramAddr_t'(base + i), wrAddrQ[i]);
			checkEq("o_ram.wdata", expQ[i], wrDataQ[i]);
		end
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic testReset();
		word_t rd;
		@(negedge clk);
		checkEq("o_dmaReq", 0, dmaReq);
		checkEq("o_irq", 0, irq);
		checkEq("o_dataOutValid", 0, dataOutValid);
		checkEq("o_ram.read", 0, ram.read);
		checkEq("o_ram.write", 0, ram.write);
		cpuRead(RegStat, rd);
		checkEq("status", expStat(ModeStop, 1'b0, 1'b0), rd);
		reportTest("reset state");
	endtask

	task automatic testRegs();
		word_t irqA;
		word_t xferA;
		word_t ctrl;
		word_t rd;
		nextBits(16, irqA);
		nextBits(16, xferA);
		nextBits(16, ctrl);
		// Keep mode at stop and the interrupt off
		ctrl = ctrl & ~16'h0070;
		cpuWrite(RegIrqAddr, irqA);
		cpuWrite(RegXferAddr, xferA);
		cpuWrite(RegCtrl, ctrl);
		cpuRead(RegIrqAddr, rd);
		checkEq("irq address", irqA, rd);
		cpuRead(RegXferAddr, rd);
		checkEq("transfer address", xferA, rd);
		cpuRead(RegCtrl, rd);
		checkEq("control", ctrl, rd);
		cpuWrite(RegCtrl, 16'h0);
		reportTest("register readback");
	endtask

	task automatic testManual();
		word_t startA;
		word_t w;
		word_t rd;
		nextBits(16, startA);
		wrAddrQ.delete();
		wrDataQ.delete();
		expQ.delete();
		cpuWrite(RegXferAddr, startA);
		cpuWrite(RegCtrl, ctrlWord(ModeManual, 1'b0));
		for (int i = 0; i < 8; i++) begin
			nextBits(16, w);
			expQ.push_back(w);
			cpuWrite(RegXferFifo, w);
		end
		waitWrites(8);
		checkWrites({startA, 2'b00}, 8);
		// FIFO drained by now
		cpuRead(RegStat, rd);
		checkEq("status", expStat(ModeManual, 1'b0, 1'b0), rd);
		cpuWrite(RegCtrl, 16'h0);
		reportTest("manual transfer");
	endtask

	task automatic testDmaWrite();
		word_t startA;
		word_t w;
		nextBits(16, startA);
		wrAddrQ.delete();
		wrDataQ.delete();
		expQ.delete();
		cpuWrite(RegXferAddr, startA);
		cpuWrite(RegCtrl, ctrlWord(ModeDmaWrite, 1'b0));
		for (int i = 0; i < 40; i++) begin
			waitDmaReq();
			nextBits(16, w);
			expQ.push_back(w);
			@(posedge clk);
			dmaAck <= 1'b1;
			cpuBus.wdata <= w;
			@(posedge clk);
			dmaAck <= 1'b0;
		end
		waitWrites(40);
		checkWrites({startA, 2'b00}, 40);
		cpuWrite(RegCtrl, 16'h0);
		reportTest("DMA write");
	endtask

	task automatic testDmaRead();
		word_t    startA;
		word_t    w;
		word_t    got;
		word_t    prevWord;
		ramAddr_t base;
		int       k;
		nextBits(16, startA);
		base = {startA, 2'b00};
		expQ.delete();
		// Preload the words the engine will fetch
		for (int i = 0; i < 8; i++) begin
			nextBits(16, w);
			expQ.push_back(w);
			ramMem[ramAddr_t'(base + i)] = w;
		end
		cpuWrite(RegXferAddr, startA);
		cpuWrite(RegCtrl, ctrlWord(ModeDmaRead, 1'b0));
		k = 0;
		prevWord = '0;
		for (int p = 0; p < 7; p++) begin
			waitRamRead();
			checkEq("o_ram.addr", ramAddr_t'(base + k), ram.addr);
			// Ack goes with the pulse that follows the read
			@(posedge clk);
			dmaAck <= (p != SkipPulse);
			@(negedge clk);
			checkEq("o_dmaReq", 1, dmaReq);
			got = dataOut;
			checkEq("o_dataOut", expQ[k], got);
			if (p == SkipPulse + 1) begin
				checkEq("o_dataOut repeat", prevWord, got);
			end
			prevWord = got;
			if (p != SkipPulse) begin
				k++;
			end
			@(posedge clk);
			dmaAck <= 1'b0;
			@(negedge clk);
			checkEq("o_dmaReq", 0, dmaReq);
		end
		cpuWrite(RegCtrl, 16'h0);
		reportTest("DMA read");
	endtask

	task automatic testIrq();
		word_t startA;
		word_t w;
		word_t rd;
		nextBits(16, startA);
		nextBits(16, w);
		cpuWrite(RegIrqAddr, startA);
		cpuWrite(RegXferAddr, startA);
		cpuWrite(RegCtrl, ctrlWord(ModeManual, 1'b1));
		cpuWrite(RegXferFifo, w);
		waitIrqHigh();
		// Sticky while enabled
		for (int i = 0; i < 2 * SlotPeriod; i++) begin
			checkEq("o_irq", 1, irq);
			@(negedge clk);
		end
		cpuRead(RegStat, rd);
		checkEq("status", expStat(ModeManual, 1'b0, 1'b1), rd);
		cpuWrite(RegCtrl, ctrlWord(ModeManual, 1'b0));
		// Still set in the cycle of the new control value
		@(negedge clk);
		checkEq("o_irq", 1, irq);
		@(negedge clk);
		checkEq("o_irq", 0, irq);
		cpuWrite(RegCtrl, 16'h0);
		reportTest("interrupt");
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int cycles;
		cpuBus      = '0;
		dmaAck      = 1'b0;
		ramData     = '0;
		lfsrState   = 16'd25994;
		errCount    = 0;
		errAtStart  = 0;
		testCount   = 0;
		failedTests = 0;
		cycles      = 0;
		@(negedge clk);
		while (!rstN) begin
			if (cycles >= Timeout) timeoutAbort("reset release");
			cycles++;
			@(negedge clk);
		end

		testReset();
		testRegs();
		testManual();
		testDmaWrite();
		testDmaRead();
		testIrq();

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			testCount, failedTests, errCount);
		if (errCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
	output logic o_clk,
	output logic o_rstN
);

	// 8 ns period
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// Reset low for the first two rising edges
	initial begin
		o_rstN = 1'b0;
		repeat (2) @(posedge o_clk);
		o_rstN <= 1'b1;
	end

endmodule

`default_nettype wire
